// ==== include/ahb_periph_cfg.svh ====
/*
 * AHB-lite peripheral subsystem configuration
 * bus widths, SRAM depth and the base/mask pair of each slave region
 */

`ifndef AHB_PERIPH_CFG_SVH
`define AHB_PERIPH_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////////////////////

`define AHB_ADDR_W 32
`define AHB_DATA_W 32

`define SRAM_DEPTH 512           // words

////////////////////////////////////////////////////////////////////////////
// address map, a slave hits when (haddr & mask) == base
////////////////////////////////////////////////////////////////////////////

`define SRAM_BASE  32'h2000_0000
`define SRAM_MASK  32'hFFFF_F800 // 2 KiB window

`define TIMER_BASE 32'h4000_0400
`define TIMER_MASK 32'hFFFF_FFC0 // 64 byte register window

`endif

// ==== hdl/ahb_pkg.sv ====
/*
 * AHB-lite bus transfer types
 * request and response bundles plus the htrans/hsize encodings
 */

`include "ahb_periph_cfg.svh"

package ahb_pkg;

   // transfer type on htrans
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_t;

   // transfer size on hsize, only up to one word
   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'b000,
      HSIZE_HALF = 3'b001,
      HSIZE_WORD = 3'b010
   } hsize_t;

   localparam logic HRESP_OKAY  = 1'b0;
   localparam logic HRESP_ERROR = 1'b1;

   // master side, address and control plus write data
   typedef struct packed {
      logic [`AHB_ADDR_W-1:0] haddr;
      htrans_t                htrans;
      logic                   hwrite;
      hsize_t                 hsize;
      logic [`AHB_DATA_W-1:0] hwdata;  // valid in the data phase
   } ahb_req_t;

   // slave side response
   typedef struct packed {
      logic [`AHB_DATA_W-1:0] hrdata;
      logic                   hreadyout;
      logic                   hresp;
   } ahb_rsp_t;

endpackage

// ==== hdl/periph_pkg.sv ====
/*
 * peripheral side types
 * data-phase slave select, timer register map and timer write decode
 */

`include "ahb_periph_cfg.svh"

package periph_pkg;

   // owner of the current data phase
   typedef enum logic [1:0] {
      SEL_IDLE  = 2'd0,
      SEL_SRAM  = 2'd1,
      SEL_TIMER = 2'd2,
      SEL_ERR   = 2'd3
   } slave_sel_t;

   // timer register index, taken from haddr[3:2]
   typedef enum logic [1:0] {
      TREG_CTRL    = 2'd0,      // offset 0x0
      TREG_COUNT   = 2'd1,      // offset 0x4
      TREG_COMPARE = 2'd2       // offset 0x8
   } timer_reg_t;

   // control word as written
   typedef struct packed {
      logic [`AHB_DATA_W-4:0] reserved;
      logic                   irq_clr;   // write 1 to drop pending
      logic                   irq_en;
      logic                   enable;
   } timer_ctrl_t;

   // one write word, seen as control fields or as a plain value
   typedef union packed {
      timer_ctrl_t            ctrl;
      logic [`AHB_DATA_W-1:0] raw;
   } timer_wdata_u;

endpackage

// ==== hdl/ahb_addr_decoder.sv ====
/*
 * AHB-lite address decoder
 * matches the address phase against the base/mask table, fires the
 * slave start strobes and registers the owner of the data phase
 */

`timescale 1ns/10ps
`include "ahb_periph_cfg.svh"

module ahb_addr_decoder (
   input  logic                   hclk_i,
   input  logic                   rst_n_i,
   input  ahb_pkg::ahb_req_t      req_i,
   input  logic                   hready_i,
   output logic                   sram_start_o,
   output logic                   timer_start_o,
   output periph_pkg::slave_sel_t dsel_o
);

   import ahb_pkg::*;
   import periph_pkg::*;

   logic       sram_hit;
   logic       timer_hit;
   logic       xfer;       // real transfer requested
   slave_sel_t dsel_nxt;
   slave_sel_t dsel_q;

   ////////////////////////////////////////////////////////////////////////////
   // address phase
   ////////////////////////////////////////////////////////////////////////////

   assign sram_hit  = (req_i.haddr & `SRAM_MASK)  == `SRAM_BASE;
   assign timer_hit = (req_i.haddr & `TIMER_MASK) == `TIMER_BASE;
   assign xfer      = req_i.htrans == NONSEQ;

   assign sram_start_o  = hready_i & xfer & sram_hit;
   assign timer_start_o = hready_i & xfer & timer_hit;

   always_comb begin
      if (!xfer) begin
         dsel_nxt = SEL_IDLE;            // idle, nothing to answer
      end else if (sram_hit) begin
         dsel_nxt = SEL_SRAM;
      end else if (timer_hit) begin
         dsel_nxt = SEL_TIMER;
      end else begin
         dsel_nxt = SEL_ERR;             // hole in the map
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // data phase owner
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         dsel_q <= SEL_IDLE;
      end else if (hready_i) begin       // held while stalled
         dsel_q <= dsel_nxt;
      end
   end

   assign dsel_o = dsel_q;

endmodule

// ==== hdl/ahb_sram.sv ====
/*
 * AHB-lite SRAM slave
 * word organised array, zero wait states, byte and halfword writes
 * through per-lane enables
 */

`timescale 1ns/10ps
`include "ahb_periph_cfg.svh"

module ahb_sram (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  ahb_pkg::ahb_req_t req_i,
   input  logic              start_i,
   output ahb_pkg::ahb_rsp_t rsp_o
);

   import ahb_pkg::*;

   localparam int unsigned LANES = `AHB_DATA_W / 8;
   localparam int unsigned OFF_W = $clog2(LANES);
   localparam int unsigned IDX_W = $clog2(`SRAM_DEPTH);

   logic [`AHB_DATA_W-1:0] mem [`SRAM_DEPTH];

   logic             active_q;               // data phase belongs to us
   logic             write_q;
   hsize_t           size_q;
   logic [OFF_W-1:0] off_q;                  // byte offset in the word
   logic [IDX_W-1:0] idx_q;
   logic [LANES-1:0] be;

   // address phase capture
   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         active_q <= 1'b0;
      end else begin
         active_q <= start_i;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (start_i) begin
         write_q <= req_i.hwrite;
         size_q  <= req_i.hsize;
         off_q   <= req_i.haddr[OFF_W-1:0];
         idx_q   <= req_i.haddr[OFF_W +: IDX_W];
      end
   end

   // byte lanes from size and offset
   always_comb begin
      case (size_q)
         HSIZE_BYTE: be = {{(LANES-1){1'b0}}, 1'b1} << off_q;
         HSIZE_HALF: be = {{(LANES-2){1'b0}}, 2'b11} << {off_q[OFF_W-1:1], 1'b0};
         default:    be = {LANES{1'b1}};
      endcase
   end

   // write lands on the edge closing the data phase
   always_ff @(posedge hclk_i) begin
      if (active_q && write_q) begin
         for (int i = 0; i < LANES; i++) begin
            if (be[i]) begin
               mem[idx_q][8*i +: 8] <= req_i.hwdata[8*i +: 8];
            end
         end
      end
   end

   assign rsp_o.hrdata    = mem[idx_q];   // async read in the data phase
   assign rsp_o.hreadyout = 1'b1;
   assign rsp_o.hresp     = HRESP_OKAY;

endmodule

// ==== hdl/ahb_timer.sv ====
/*
 * AHB-lite timer slave
 * free running counter with compare match, wrap to zero and a sticky
 * pending flag that drives the interrupt when enabled
 */

`timescale 1ns/10ps
`include "ahb_periph_cfg.svh"

module ahb_timer (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  ahb_pkg::ahb_req_t req_i,
   input  logic              start_i,
   output ahb_pkg::ahb_rsp_t rsp_o,
   output logic              irq_o
);

   import ahb_pkg::*;
   import periph_pkg::*;

   logic                   active_q;
   logic                   write_q;
   timer_reg_t             reg_q;
   timer_wdata_u           wdata;

   logic                   wr_ctrl;
   logic                   wr_count;
   logic                   wr_compare;
   logic                   match;

   logic                   enable_q;
   logic                   irq_en_q;
   logic                   pending_q;
   logic                   irq_q;
   logic [`AHB_DATA_W-1:0] count_q;
   logic [`AHB_DATA_W-1:0] compare_q;

   ////////////////////////////////////////////////////////////////////////////
   // bus side
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         active_q <= 1'b0;
      end else begin
         active_q <= start_i;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (start_i) begin
         reg_q   <= timer_reg_t'(req_i.haddr[3:2]);   // word offset
         write_q <= req_i.hwrite;
      end
   end

   assign wdata      = req_i.hwdata;
   assign wr_ctrl    = active_q & write_q & (reg_q == TREG_CTRL);
   assign wr_count   = active_q & write_q & (reg_q == TREG_COUNT);
   assign wr_compare = active_q & write_q & (reg_q == TREG_COMPARE);

   ////////////////////////////////////////////////////////////////////////////
   // counter and interrupt
   ////////////////////////////////////////////////////////////////////////////

   assign match = enable_q & (count_q == compare_q);

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         enable_q  <= 1'b0;
         irq_en_q  <= 1'b0;
         pending_q <= 1'b0;
         irq_q     <= 1'b0;
         count_q   <= '0;
         compare_q <= '0;
      end else begin
         if (wr_ctrl) begin
            enable_q <= wdata.ctrl.enable;
            irq_en_q <= wdata.ctrl.irq_en;
         end

         if (wr_compare) compare_q <= wdata.raw;

         if (wr_count) begin
            count_q <= wdata.raw;            // bus write beats the count
         end else if (match) begin
            count_q <= '0;
         end else if (enable_q) begin
            count_q <= count_q + 1'b1;
         end

         // clear wins over a match on the same edge
         if (wr_ctrl && wdata.ctrl.irq_clr) begin
            pending_q <= 1'b0;
         end else if (match) begin
            pending_q <= 1'b1;
         end

         irq_q <= pending_q & irq_en_q;
      end
   end

   assign irq_o = irq_q;

   // read mux, pending shows up in ctrl bit 3
   always_comb begin
      rsp_o.hreadyout = 1'b1;
      rsp_o.hresp     = HRESP_OKAY;

      case (reg_q)
         TREG_CTRL:    rsp_o.hrdata = {{(`AHB_DATA_W-4){1'b0}}, pending_q, 1'b0,
                                       irq_en_q, enable_q};
         TREG_COUNT:   rsp_o.hrdata = count_q;
         TREG_COMPARE: rsp_o.hrdata = compare_q;
         default:      rsp_o.hrdata = '0;
      endcase
   end

endmodule

// ==== hdl/ahb_resp_mux.sv ====
/*
 * AHB-lite response multiplexer
 * forwards the response of the data-phase owner and builds the
 * two-cycle error response for unmapped transfers
 */

`timescale 1ns/10ps

module ahb_resp_mux (
   input  logic                   hclk_i,
   input  logic                   rst_n_i,
   input  periph_pkg::slave_sel_t dsel_i,
   input  ahb_pkg::ahb_rsp_t      sram_rsp_i,
   input  ahb_pkg::ahb_rsp_t      timer_rsp_i,
   output ahb_pkg::ahb_rsp_t      rsp_o
);

   import ahb_pkg::*;
   import periph_pkg::*;

   logic err_q;   // 0 first error cycle, 1 second

   ////////////////////////////////////////////////////////////////////////////
   // error response sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge hclk_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= (dsel_i == SEL_ERR) & ~err_q;   // back to 0 after the 2nd
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // response select
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      rsp_o.hrdata    = '0;      // idle data phase, zero wait OKAY
      rsp_o.hreadyout = 1'b1;
      rsp_o.hresp     = HRESP_OKAY;

      case (dsel_i)
         SEL_SRAM:  rsp_o = sram_rsp_i;
         SEL_TIMER: rsp_o = timer_rsp_i;
         SEL_ERR: begin
            rsp_o.hreadyout = err_q;        // stall once, then release
            rsp_o.hresp     = HRESP_ERROR;
         end
         default: ;
      endcase
   end

endmodule

// ==== hdl/ahb_periph_top.sv ====
/*
 * AHB-lite peripheral subsystem top
 * decoder, SRAM slave, timer slave and response multiplexer on one bus
 */

`timescale 1ns/10ps

module ahb_periph_top (
   input  logic              hclk_i,
   input  logic              rst_n_i,
   input  ahb_pkg::ahb_req_t req_i,
   output ahb_pkg::ahb_rsp_t rsp_o,
   output logic              irq_o
);

   import ahb_pkg::*;
   import periph_pkg::*;

   logic       sram_start;
   logic       timer_start;
   slave_sel_t dsel;          // data phase owner
   ahb_rsp_t   sram_rsp;
   ahb_rsp_t   timer_rsp;

   ahb_addr_decoder u_decoder (
      .hclk_i        ( hclk_i          ),
      .rst_n_i       ( rst_n_i         ),
      .req_i         ( req_i           ),
      .hready_i      ( rsp_o.hreadyout ),   // combined hready back in
      .sram_start_o  ( sram_start      ),
      .timer_start_o ( timer_start     ),
      .dsel_o        ( dsel            )
   );

   ahb_sram u_sram (
      .hclk_i  ( hclk_i     ),
      .rst_n_i ( rst_n_i    ),
      .req_i   ( req_i      ),
      .start_i ( sram_start ),
      .rsp_o   ( sram_rsp   )
   );

   ahb_timer u_timer (
      .hclk_i  ( hclk_i      ),
      .rst_n_i ( rst_n_i     ),
      .req_i   ( req_i       ),
      .start_i ( timer_start ),
      .rsp_o   ( timer_rsp   ),
      .irq_o   ( irq_o       )
   );

   ahb_resp_mux u_resp_mux (
      .hclk_i      ( hclk_i    ),
      .rst_n_i     ( rst_n_i   ),
      .dsel_i      ( dsel      ),
      .sram_rsp_i  ( sram_rsp  ),
      .timer_rsp_i ( timer_rsp ),
      .rsp_o       ( rsp_o     )
   );

endmodule

// ==== tb/tb_clk_gen.sv ====
/*
 * testbench clock and reset generator
 * 10 ns clock, reset held low for the first 10 cycles
 */

`timescale 1ns/10ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (10) @(posedge clk_o);
      @(negedge clk_o);                // release away from the sampling edge
      rst_n_o = 1'b1;
   end

endmodule

// ==== tb/tb_ahb_periph.sv ====
/*
 * testbench for the AHB-lite peripheral subsystem
 * random single transfers against a byte shadow of the SRAM and a
 * shadow of the timer registers, error response and timer interrupt
 */

`timescale 1ns/10ps
`include "ahb_periph_cfg.svh"

module tb_ahb_periph;

   import ahb_pkg::*;
   import periph_pkg::*;

   localparam int N_FILL  = `SRAM_DEPTH;
   localparam int N_WORD  = 48;
   localparam int N_SUB   = 64;
   localparam int N_ERR   = 6;
   localparam int N_TIMER = 12;
   localparam int C_MAX   = 40;
   localparam int HOLD    = 8;
   localparam int CYCLE_LIMIT = 4 * (N_FILL + 2 * N_WORD + 2 * N_SUB + 2 * N_ERR
                                     + N_TIMER + C_MAX + 4 + 2 + HOLD);

   logic     hclk;
   logic     rst_n;
   ahb_req_t req;
   ahb_rsp_t rsp;
   logic     irq;
   int       cycle_cnt = 0;

   logic [7:0]  shadow [`SRAM_DEPTH * 4];    // byte addressed SRAM model
   logic        tmr_enable;
   logic        tmr_irq_en;
   logic        tmr_pending;
   int          touched [$];

   tb_clk_gen u_clk_gen (
      .clk_o   ( hclk  ),
      .rst_n_o ( rst_n )
   );

   ahb_periph_top UUT (
      .hclk_i  ( hclk  ),
      .rst_n_i ( rst_n ),
      .req_i   ( req   ),
      .rsp_o   ( rsp   ),
      .irq_o   ( irq   )
   );

   ////////////////////////////////////////////////////////////////////////////
   // failure reporting and compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic value_error(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, sig, got, exp);
      abort_run();
   endtask

   function automatic ahb_rsp_t make_rsp(logic [31:0] data, logic ready, logic resp);
      ahb_rsp_t r;
      r.hrdata    = data;
      r.hreadyout = ready;
      r.hresp     = resp;
      return r;
   endfunction

   task automatic check_rsp(input string what, input ahb_rsp_t got, input ahb_rsp_t exp,
                            input bit with_data);
      if (with_data && got.hrdata !== exp.hrdata) begin
         value_error({"rsp_o.hrdata (", what, ")"}, got.hrdata, exp.hrdata);
      end else if (got.hreadyout !== exp.hreadyout) begin
         value_error({"rsp_o.hreadyout (", what, ")"}, 32'(got.hreadyout),
                     32'(exp.hreadyout));
      end else if (got.hresp !== exp.hresp) begin
         value_error({"rsp_o.hresp (", what, ")"}, 32'(got.hresp), 32'(exp.hresp));
      end
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp) begin
         value_error("irq_o", 32'(got), 32'(exp));
      end
   endtask

   // timeout on a hung bus or a timer that never fires
   always @(posedge hclk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("timeout: run still going after %0d cycles", cycle_cnt);
         abort_run();
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] fill_word(logic [31:0] a);
      return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_C3A5;
   endfunction

   // AHB byte lanes follow the address, lane n is hwdata[8n+7:8n]
   function automatic void model_write(logic [31:0] addr, hsize_t size, logic [31:0] data);
      int word;
      int lane;
      word = int'(addr[10:2]);
      for (int k = 0; k < (1 << int'(size)); k++) begin
         lane = int'(addr[1:0]) + k;
         shadow[4 * word + lane] = data[8 * lane +: 8];
      end
   endfunction

   function automatic logic [31:0] shadow_word(int idx);
      return {shadow[4 * idx + 3], shadow[4 * idx + 2], shadow[4 * idx + 1], shadow[4 * idx]};
   endfunction

   function automatic logic [31:0] ctrl_word();
      return {28'b0, tmr_pending, 1'b0, tmr_irq_en, tmr_enable};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // bus master
   ////////////////////////////////////////////////////////////////////////////

   task automatic bus_xfer(input logic [31:0] addr, input logic wr, input hsize_t size,
                           input logic [31:0] wdata, output ahb_rsp_t first,
                           output ahb_rsp_t last, output int cycles);
      repeat ($urandom_range(0, 2)) @(negedge hclk);   // idle gap
      @(negedge hclk);
      req.haddr  = addr;
      req.htrans = NONSEQ;
      req.hwrite = wr;
      req.hsize  = size;
      while (!rsp.hreadyout) @(negedge hclk);          // request held while stalled
      @(negedge hclk);                                 // data phase
      first      = rsp;
      last       = rsp;
      cycles     = 1;
      req.htrans = IDLE;
      req.hwdata = wdata;
      while (!last.hreadyout) begin
         @(negedge hclk);
         last = rsp;
         cycles++;
      end
   endtask

   task automatic sram_write(input logic [31:0] addr, input hsize_t size,
                             input logic [31:0] data);
      ahb_rsp_t first;
      ahb_rsp_t last;
      int       cycles;
      bus_xfer(addr, 1'b1, size, data, first, last, cycles);
      check_rsp("sram write", first, make_rsp('0, 1'b1, HRESP_OKAY), 1'b0);
      model_write(addr, size, data);
   endtask

   task automatic sram_read(input int idx);
      ahb_rsp_t first;
      ahb_rsp_t last;
      int       cycles;
      bus_xfer(`SRAM_BASE + (32'(idx) << 2), 1'b0, HSIZE_WORD, '0, first, last, cycles);
      check_rsp("sram read", first, make_rsp(shadow_word(idx), 1'b1, HRESP_OKAY), 1'b1);
   endtask

   task automatic timer_write(input timer_reg_t r, input logic [31:0] data);
      ahb_rsp_t first;
      ahb_rsp_t last;
      int       cycles;
      bus_xfer(`TIMER_BASE + {28'b0, r, 2'b00}, 1'b1, HSIZE_WORD, data, first, last, cycles);
      check_rsp("timer write", first, make_rsp('0, 1'b1, HRESP_OKAY), 1'b0);
   endtask

   task automatic timer_read(input timer_reg_t r, input logic [31:0] exp);
      ahb_rsp_t first;
      ahb_rsp_t last;
      int       cycles;
      bus_xfer(`TIMER_BASE + {28'b0, r, 2'b00}, 1'b0, HSIZE_WORD, '0, first, last, cycles);
      check_rsp("timer read", first, make_rsp(exp, 1'b1, HRESP_OKAY), 1'b1);
   endtask

   function automatic logic [31:0] unmapped_addr(int k);
      logic [31:0] a;
      case (k)
         0: a = `SRAM_BASE + 32'h800;                 // one past the SRAM window
         1: a = `TIMER_BASE + 32'h40;
         default: begin
            a = $urandom;
            while (((a & `SRAM_MASK) == `SRAM_BASE) || ((a & `TIMER_MASK) == `TIMER_BASE))
               a = $urandom;
         end
      endcase
      return a;
   endfunction

   task automatic unmapped_access(input logic [31:0] addr);
      ahb_rsp_t first;
      ahb_rsp_t last;
      int       cycles;
      bus_xfer(addr, $urandom_range(0, 1) == 1, HSIZE_WORD, $urandom, first, last, cycles);
      check_rsp("error cycle 1", first, make_rsp('0, 1'b0, HRESP_ERROR), 1'b0);
      check_rsp("error cycle 2", last, make_rsp('0, 1'b1, HRESP_ERROR), 1'b0);
      if (cycles != 2) begin
         $display("error response at 0x%h took %0d cycles instead of 2", addr, cycles);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      timer_wdata_u ctrl;
      int           idx;
      int           off;
      int           c;
      int           waited;
      hsize_t       size;
      logic [31:0]  cnt_val;
      logic [31:0]  cmp_val;

      void'($urandom(12));
      req         = '0;
      tmr_enable  = 1'b0;
      tmr_irq_en  = 1'b0;
      tmr_pending = 1'b0;

      @(posedge rst_n);
      @(negedge hclk);
      check_rsp("after reset", rsp, make_rsp('0, 1'b1, HRESP_OKAY), 1'b0);
      check_irq(irq, 1'b0);

      // preload the whole array so every read has a known value
      for (int i = 0; i < N_FILL; i++) begin
         sram_write(`SRAM_BASE + (32'(i) << 2), HSIZE_WORD,
                    fill_word(`SRAM_BASE + (32'(i) << 2)));
      end

      for (int i = 0; i < N_WORD; i++) begin
         idx = $urandom_range(0, `SRAM_DEPTH - 1);
         sram_write(`SRAM_BASE + (32'(idx) << 2), HSIZE_WORD, $urandom);
      end
      for (int i = 0; i < N_WORD; i++) begin
         sram_read($urandom_range(0, `SRAM_DEPTH - 1));
      end

      // sub-word writes, unused lanes carry random junk
      for (int i = 0; i < N_SUB; i++) begin
         idx  = $urandom_range(0, `SRAM_DEPTH - 1);
         size = ($urandom_range(0, 1) == 0) ? HSIZE_BYTE : HSIZE_HALF;
         off  = (size == HSIZE_BYTE) ? $urandom_range(0, 3) : 2 * $urandom_range(0, 1);
         sram_write(`SRAM_BASE + (32'(idx) << 2) + 32'(off), size, $urandom);
         touched.push_back(idx);
      end
      foreach (touched[i]) sram_read(touched[i]);

      for (int k = 0; k < N_ERR; k++) begin
         unmapped_access(unmapped_addr(k));
         sram_read($urandom_range(0, `SRAM_DEPTH - 1));
      end

      // timer stopped, registers read back as written
      cnt_val = $urandom;
      cmp_val = $urandom;
      timer_write(TREG_CTRL, '0);
      timer_write(TREG_COUNT, cnt_val);
      timer_write(TREG_COMPARE, cmp_val);
      timer_read(TREG_COUNT, cnt_val);
      timer_read(TREG_COMPARE, cmp_val);
      timer_read(TREG_CTRL, ctrl_word());

      // compare interrupt
      c = $urandom_range(8, C_MAX);
      timer_write(TREG_COUNT, '0);
      timer_write(TREG_COMPARE, 32'(c));
      ctrl.raw             = '0;
      ctrl.ctrl.enable     = 1'b1;
      ctrl.ctrl.irq_en     = 1'b1;
      timer_write(TREG_CTRL, ctrl.raw);
      tmr_enable = 1'b1;
      tmr_irq_en = 1'b1;
      waited     = 0;
      while (irq !== 1'b1 && waited < c + 4) begin
         @(negedge hclk);
         waited++;
      end
      check_irq(irq, 1'b1);
      tmr_pending = 1'b1;                // sticky until cleared
      timer_read(TREG_CTRL, ctrl_word());

      ctrl.raw           = '0;
      ctrl.ctrl.irq_en   = 1'b1;
      ctrl.ctrl.irq_clr  = 1'b1;
      timer_write(TREG_CTRL, ctrl.raw);
      tmr_enable  = 1'b0;
      tmr_pending = 1'b0;
      waited      = 0;
      while (irq !== 1'b0 && waited < 2) begin
         @(negedge hclk);
         waited++;
      end
      check_irq(irq, 1'b0);
      repeat (HOLD) begin
         @(negedge hclk);
         check_irq(irq, 1'b0);
      end
      timer_read(TREG_CTRL, ctrl_word());

      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== ahb_periph.f ====
+incdir+include
hdl/ahb_pkg.sv
hdl/periph_pkg.sv
hdl/ahb_addr_decoder.sv
hdl/ahb_sram.sv
hdl/ahb_timer.sv
hdl/ahb_resp_mux.sv
hdl/ahb_periph_top.sv
tb/tb_clk_gen.sv
tb/tb_ahb_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ahb_periph.f --top-module tb_ahb_periph -o sim_tb \
   && ./obj_dir/sim_tb \
   || { echo "simulation build or run failed"; exit 1; }
